// File: dual_issue_hazard.f
+incdir+test
hdl/issue_pkg.sv
hdl/inst_decoder.sv
hdl/pair_hazard_check.sv
hdl/pair_buffer.sv
hdl/lane_steer.sv
hdl/dual_issue_hazard_unit.sv
test/tb_dual_issue.sv

// File: hdl/dual_issue_hazard_unit.sv
`timescale 1ns/1ps

module dual_issue_hazard_unit
  import issue_pkg::*;
#(
  parameter int addr_width = 32,
  parameter int id_width   = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  logic [inst_width-1:0] in_inst0,
  input  logic [addr_width-1:0] in_pc0,
  input  logic [id_width-1:0]   in_id0,
  input  logic [inst_width-1:0] in_inst1,
  input  logic [addr_width-1:0] in_pc1,
  input  logic [id_width-1:0]   in_id1,
  input  logic                  ex_load_valid,
  input  reg_idx_t              ex_load_rt,
  input  logic                  out_ready,
  output logic                  in_ready,
  output logic                  out_valid,
  output logic                  out_swapped,
  output logic [inst_width-1:0] lane0_inst,
  output logic [addr_width-1:0] lane0_pc,
  output logic [id_width-1:0]   lane0_id,
  output logic [inst_width-1:0] lane1_inst,
  output logic [addr_width-1:0] lane1_pc,
  output logic [id_width-1:0]   lane1_id
);

  logic                  buf_valid0;
  logic [inst_width-1:0] buf_inst0;
  logic [addr_width-1:0] buf_pc0;
  logic [id_width-1:0]   buf_id0;
  logic                  buf_valid1;
  logic [inst_width-1:0] buf_inst1;
  logic [addr_width-1:0] buf_pc1;
  logic [id_width-1:0]   buf_id1;

  reg_idx_t    rs0, rt0, dst0;
  logic        reads_rs0, reads_rt0, writes_dst0;
  lane_class_e lane_class0;
  reg_idx_t    rs1, rt1;
  logic        reads_rs1, reads_rt1;
  lane_class_e lane_class1;

  issue_e decision;
  logic   swap;
  logic   issue_fire;

  ////////////////////////////////////////////////////////////////////////////

  pair_buffer #(.addr_width(addr_width), .id_width(id_width)) u_pair_buffer (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid),
    .in_inst0(in_inst0), .in_pc0(in_pc0), .in_id0(in_id0),
    .in_inst1(in_inst1), .in_pc1(in_pc1), .in_id1(in_id1),
    .decision(decision), .issue_fire(issue_fire), .in_ready(in_ready),
    .buf_valid0(buf_valid0), .buf_inst0(buf_inst0), .buf_pc0(buf_pc0), .buf_id0(buf_id0),
    .buf_valid1(buf_valid1), .buf_inst1(buf_inst1), .buf_pc1(buf_pc1), .buf_id1(buf_id1)
  );

  inst_decoder u_decoder0 (
    .inst(buf_inst0), .rs(rs0), .rt(rt0), .rd(),
    .reads_rs(reads_rs0), .reads_rt(reads_rt0),
    .dst(dst0), .writes_dst(writes_dst0), .lane_class(lane_class0)
  );

  // younger destination only matters once it becomes the older.
  inst_decoder u_decoder1 (
    .inst(buf_inst1), .rs(rs1), .rt(rt1), .rd(),
    .reads_rs(reads_rs1), .reads_rt(reads_rt1),
    .dst(), .writes_dst(), .lane_class(lane_class1)
  );

  pair_hazard_check u_pair_hazard_check (
    .valid0(buf_valid0), .rs0(rs0), .rt0(rt0), .reads_rs0(reads_rs0),
    .reads_rt0(reads_rt0), .dst0(dst0), .writes_dst0(writes_dst0),
    .lane_class0(lane_class0),
    .valid1(buf_valid1), .rs1(rs1), .rt1(rt1), .reads_rs1(reads_rs1),
    .reads_rt1(reads_rt1), .lane_class1(lane_class1),
    .ex_load_valid(ex_load_valid), .ex_load_rt(ex_load_rt),
    .decision(decision), .swap(swap)
  );

  lane_steer #(.addr_width(addr_width), .id_width(id_width)) u_lane_steer (
    .clk(clk), .rst_n(rst_n),
    .buf_valid0(buf_valid0), .buf_inst0(buf_inst0), .buf_pc0(buf_pc0), .buf_id0(buf_id0),
    .buf_valid1(buf_valid1), .buf_inst1(buf_inst1), .buf_pc1(buf_pc1), .buf_id1(buf_id1),
    .decision(decision), .swap(swap), .out_ready(out_ready),
    .issue_fire(issue_fire), .out_valid(out_valid), .out_swapped(out_swapped),
    .lane0_inst(lane0_inst), .lane0_pc(lane0_pc), .lane0_id(lane0_id),
    .lane1_inst(lane1_inst), .lane1_pc(lane1_pc), .lane1_id(lane1_id)
  );

endmodule

// File: hdl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
  import issue_pkg::*;
(
  input  logic [inst_width-1:0] inst,
  output reg_idx_t              rs,
  output reg_idx_t              rt,
  output reg_idx_t              rd,
  output logic                  reads_rs,
  output logic                  reads_rt,
  output reg_idx_t              dst,
  output logic                  writes_dst,
  output lane_class_e           lane_class
);

  opcode_e    op;
  logic [1:0] group;
  logic       dst_is_rd;

  assign op    = opcode_e'(inst[opcode_msb:opcode_lsb]);
  assign group = inst[opcode_msb -: 2];

  assign rs = inst[rs_msb:rs_lsb];
  assign rt = inst[rt_msb:rt_lsb];
  assign rd = inst[rd_msb:rd_lsb];

  assign dst = dst_is_rd ? rd : rt;

  // register use per group.
  always_comb begin
    reads_rs   = 1'b0;
    reads_rt   = 1'b0;
    writes_dst = 1'b0;
    dst_is_rd  = 1'b0;
    case (group)
      grp_alu: begin
        if (op == op_jr) begin
          reads_rs = 1'b1;
        end else if (op != op_nop) begin
          reads_rs   = 1'b1;
          reads_rt   = 1'b1;
          writes_dst = 1'b1;
          dst_is_rd  = 1'b1;
        end
      end
      grp_imm: begin
        reads_rs   = 1'b1;
        writes_dst = 1'b1;
      end
      grp_mem: begin
        case (op)
          op_lw: begin
            reads_rs   = 1'b1;
            writes_dst = 1'b1;
          end
          op_sw: begin
            reads_rs = 1'b1;
            reads_rt = 1'b1;
          end
          op_la:   writes_dst = 1'b1;
          op_sa:   reads_rt = 1'b1;
          default: writes_dst = 1'b0;
        endcase
      end
      default: writes_dst = 1'b0;   // jumps touch no register.
    endcase
  end

  always_comb begin
    case (group)
      grp_mem: lane_class = class_memory;
      grp_ctl: lane_class = class_branch;
      default: begin
        if (op == op_cmp || op == op_test || op == op_cmpi || op == op_testi) begin
          lane_class = class_branch;   // flag setters stay with the branch.
        end else begin
          lane_class = class_any;
        end
      end
    endcase
  end

endmodule

// File: hdl/issue_pkg.sv
package issue_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // instruction word layout
  ////////////////////////////////////////////////////////////////////////////

  localparam int inst_width = 32;

  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int rs_msb     = 25;
  localparam int rs_lsb     = 21;
  localparam int rt_msb     = 20;
  localparam int rt_lsb     = 16;
  localparam int rd_msb     = 15;
  localparam int rd_lsb     = 11;

  typedef logic [4:0] reg_idx_t;

  // top two opcode bits select the group.
  localparam logic [1:0] grp_alu = 2'b00;
  localparam logic [1:0] grp_imm = 2'b01;
  localparam logic [1:0] grp_mem = 2'b10;
  localparam logic [1:0] grp_ctl = 2'b11;

  ////////////////////////////////////////////////////////////////////////////
  // opcodes and classes
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [5:0] {
    op_nop   = 6'h00,
    op_jr    = 6'h01,
    op_cmp   = 6'h02,
    op_test  = 6'h03,
    op_add   = 6'h04,
    op_sub   = 6'h05,
    op_addi  = 6'h10,
    op_subi  = 6'h11,
    op_cmpi  = 6'h12,
    op_testi = 6'h13,
    op_lw    = 6'h20,
    op_sw    = 6'h21,
    op_la    = 6'h22,
    op_sa    = 6'h23,
    op_jmp   = 6'h30,
    op_jo    = 6'h31,
    op_je    = 6'h32
  } opcode_e;

  typedef enum logic [1:0] {
    class_any    = 2'd0,   // either lane.
    class_branch = 2'd1,   // lane 0 only.
    class_memory = 2'd2    // lane 1 only.
  } lane_class_e;

  typedef enum logic [1:0] {
    issue_none  = 2'd0,
    issue_older = 2'd1,
    issue_both  = 2'd2
  } issue_e;

  localparam logic [inst_width-1:0] nop_instruction = '0;

endpackage

// File: hdl/lane_steer.sv
`timescale 1ns/1ps

module lane_steer
  import issue_pkg::*;
#(
  parameter int addr_width = 32,
  parameter int id_width   = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  buf_valid0,
  input  logic [inst_width-1:0] buf_inst0,
  input  logic [addr_width-1:0] buf_pc0,
  input  logic [id_width-1:0]   buf_id0,
  input  logic                  buf_valid1,
  input  logic [inst_width-1:0] buf_inst1,
  input  logic [addr_width-1:0] buf_pc1,
  input  logic [id_width-1:0]   buf_id1,
  input  issue_e                decision,
  input  logic                  swap,
  input  logic                  out_ready,
  output logic                  issue_fire,
  output logic                  out_valid,
  output logic                  out_swapped,
  output logic [inst_width-1:0] lane0_inst,
  output logic [addr_width-1:0] lane0_pc,
  output logic [id_width-1:0]   lane0_id,
  output logic [inst_width-1:0] lane1_inst,
  output logic [addr_width-1:0] lane1_pc,
  output logic [id_width-1:0]   lane1_id
);

  logic                  take0;
  logic                  take1;
  logic                  older_on_lane1;
  logic [inst_width-1:0] nxt_inst0;
  logic [addr_width-1:0] nxt_pc0;
  logic [id_width-1:0]   nxt_id0;
  logic [inst_width-1:0] nxt_inst1;
  logic [addr_width-1:0] nxt_pc1;
  logic [id_width-1:0]   nxt_id1;

  assign issue_fire = (decision != issue_none) && (!out_valid || out_ready);

  assign take0 = buf_valid0 && (decision != issue_none);
  assign take1 = buf_valid1 && (decision == issue_both);

  // a lone memory op goes to lane 1.
  assign older_on_lane1 = take1 ? swap : (buf_inst0[opcode_msb -: 2] == grp_mem);

  always_comb begin
    nxt_inst0 = nop_instruction;
    nxt_pc0   = '0;
    nxt_id0   = '0;
    nxt_inst1 = nop_instruction;
    nxt_pc1   = '0;
    nxt_id1   = '0;
    if (take0 && older_on_lane1) begin
      nxt_inst1 = buf_inst0;
      nxt_pc1   = buf_pc0;
      nxt_id1   = buf_id0;
    end else if (take0) begin
      nxt_inst0 = buf_inst0;
      nxt_pc0   = buf_pc0;
      nxt_id0   = buf_id0;
    end
    if (take1 && older_on_lane1) begin
      nxt_inst0 = buf_inst1;
      nxt_pc0   = buf_pc1;
      nxt_id0   = buf_id1;
    end else if (take1) begin
      nxt_inst1 = buf_inst1;
      nxt_pc1   = buf_pc1;
      nxt_id1   = buf_id1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid   <= 1'b0;
      out_swapped <= 1'b0;
      lane0_inst  <= nop_instruction;
      lane0_pc    <= '0;
      lane0_id    <= '0;
      lane1_inst  <= nop_instruction;
      lane1_pc    <= '0;
      lane1_id    <= '0;
    end else if (issue_fire) begin
      out_valid   <= 1'b1;
      out_swapped <= take1 && swap;   // only a full pair can swap.
      lane0_inst  <= nxt_inst0;
      lane0_pc    <= nxt_pc0;
      lane0_id    <= nxt_id0;
      lane1_inst  <= nxt_inst1;
      lane1_pc    <= nxt_pc1;
      lane1_id    <= nxt_id1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

endmodule

// File: hdl/pair_buffer.sv
`timescale 1ns/1ps

module pair_buffer
  import issue_pkg::*;
#(
  parameter int addr_width = 32,
  parameter int id_width   = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  logic [inst_width-1:0] in_inst0,
  input  logic [addr_width-1:0] in_pc0,
  input  logic [id_width-1:0]   in_id0,
  input  logic [inst_width-1:0] in_inst1,
  input  logic [addr_width-1:0] in_pc1,
  input  logic [id_width-1:0]   in_id1,
  input  issue_e                decision,
  input  logic                  issue_fire,
  output logic                  in_ready,
  output logic                  buf_valid0,
  output logic [inst_width-1:0] buf_inst0,
  output logic [addr_width-1:0] buf_pc0,
  output logic [id_width-1:0]   buf_id0,
  output logic                  buf_valid1,
  output logic [inst_width-1:0] buf_inst1,
  output logic [addr_width-1:0] buf_pc1,
  output logic [id_width-1:0]   buf_id1
);

  logic fire_older;
  logic fire_both;
  logic drains;
  logic load_pair;
  logic shift_up;

  assign fire_older = issue_fire && (decision == issue_older);
  assign fire_both  = issue_fire && (decision == issue_both);

  // buffer is empty at the next edge.
  assign drains = fire_both || (fire_older && !buf_valid1);

  // slot 1 never holds alone, so slot 0 tells empty.
  assign in_ready  = !buf_valid0 || drains;
  assign load_pair = in_valid && in_ready;
  assign shift_up  = fire_older && buf_valid1;

  ////////////////////////////////////////////////////////////////////////////
  // slot valid bits
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      buf_valid0 <= 1'b0;
      buf_valid1 <= 1'b0;
    end else if (load_pair) begin
      buf_valid0 <= 1'b1;
      buf_valid1 <= 1'b1;
    end else if (fire_older) begin
      buf_valid0 <= buf_valid1;   // younger moves forward.
      buf_valid1 <= 1'b0;
    end else if (fire_both) begin
      buf_valid0 <= 1'b0;
      buf_valid1 <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // slot payload
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load_pair) begin
      buf_inst0 <= in_inst0;
      buf_pc0   <= in_pc0;
      buf_id0   <= in_id0;
      buf_inst1 <= in_inst1;
      buf_pc1   <= in_pc1;
      buf_id1   <= in_id1;
    end else if (shift_up) begin
      buf_inst0 <= buf_inst1;
      buf_pc0   <= buf_pc1;
      buf_id0   <= buf_id1;
    end
  end

endmodule

// File: hdl/pair_hazard_check.sv
`timescale 1ns/1ps

module pair_hazard_check
  import issue_pkg::*;
(
  input  logic        valid0,
  input  reg_idx_t    rs0,
  input  reg_idx_t    rt0,
  input  logic        reads_rs0,
  input  logic        reads_rt0,
  input  reg_idx_t    dst0,
  input  logic        writes_dst0,
  input  lane_class_e lane_class0,
  input  logic        valid1,
  input  reg_idx_t    rs1,
  input  reg_idx_t    rt1,
  input  logic        reads_rs1,
  input  logic        reads_rt1,
  input  lane_class_e lane_class1,
  input  logic        ex_load_valid,
  input  reg_idx_t    ex_load_rt,
  output issue_e      decision,
  output logic        swap
);

  logic load_hit0;
  logic load_hit1;
  logic raw_hit;
  logic lane_clash;

  function automatic logic reads_reg(
    input logic     use_rs,
    input reg_idx_t src_s,
    input logic     use_rt,
    input reg_idx_t src_t,
    input reg_idx_t target
  );
    return (use_rs && src_s == target) || (use_rt && src_t == target);
  endfunction

  assign load_hit0 = reads_reg(reads_rs0, rs0, reads_rt0, rt0, ex_load_rt);
  assign load_hit1 = reads_reg(reads_rs1, rs1, reads_rt1, rt1, ex_load_rt);

  // younger reads what the older writes.
  assign raw_hit = writes_dst0 && reads_reg(reads_rs1, rs1, reads_rt1, rt1, dst0);

  // both want the same special lane.
  assign lane_clash = (lane_class0 == lane_class1) && (lane_class0 != class_any);

  ////////////////////////////////////////////////////////////////////////////
  // ordered decision rules
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (!valid0 && !valid1) begin
      decision = issue_none;
    end else if (ex_load_valid && ((valid0 && load_hit0) || (valid1 && load_hit1))) begin
      decision = issue_none;   // load-use stall.
    end else if (!(valid0 && valid1)) begin
      decision = issue_older;
    end else if (raw_hit || lane_clash) begin
      decision = issue_older;  // split the pair.
    end else begin
      decision = issue_both;
    end
  end

  // older to lane 1 when it must sit on the memory lane or yield lane 0.
  assign swap = (lane_class0 == class_memory) || (lane_class1 == class_branch);

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dual_issue_hazard.f \
  --top-module tb_dual_issue -o tb_dual_issue \
  && ./obj_dir/tb_dual_issue | tee /dev/stderr | grep -qx "Test OK" \
  && echo "simulation passed" \
  || { echo "simulation did not pass"; exit 1; }

// File: test/tb_cases.svh
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// each row gives index and name, the older and younger instruction, load cycles,
// load rt, expected stall and group count, then per group the lane 0 source,
// lane 1 source and out_swapped.
localparam int n_cases  = 13;
localparam int src_old  = 0;
localparam int src_yng  = 1;
localparam int src_none = 2;

task automatic load_case_table();
  set_case(0, "independent alu pair",
           encode_r(op_add, 1, 2, 3), encode_r(op_sub, 4, 5, 6),
           0, 0, 0, 1, src_old, src_yng, 0, src_none, src_none, 0);
  set_case(1, "immediate then alu",
           encode_i(op_addi, 1, 7), encode_r(op_add, 2, 3, 8),
           0, 0, 0, 1, src_old, src_yng, 0, src_none, src_none, 0);
  set_case(2, "load then alu swapped",
           encode_i(op_lw, 1, 10), encode_r(op_add, 2, 3, 11),
           0, 0, 0, 1, src_yng, src_old, 1, src_none, src_none, 0);
  set_case(3, "alu then branch swapped",
           encode_r(op_add, 1, 2, 12), encode_i(op_je, 0, 0),
           0, 0, 0, 1, src_yng, src_old, 1, src_none, src_none, 0);
  set_case(4, "compare then load straight",
           encode_r(op_cmp, 1, 2, 20), encode_i(op_lw, 4, 13),
           0, 0, 0, 1, src_old, src_yng, 0, src_none, src_none, 0);
  set_case(5, "two branches split",
           encode_i(op_jmp, 0, 0), encode_i(op_je, 0, 0),
           0, 0, 0, 2, src_old, src_none, 0, src_yng, src_none, 0);
  set_case(6, "load and store split",
           encode_i(op_lw, 1, 5), encode_i(op_sw, 2, 3),
           0, 0, 0, 2, src_none, src_old, 0, src_none, src_yng, 0);
  set_case(7, "add feeds sub split",
           encode_r(op_add, 1, 2, 9), encode_r(op_sub, 9, 3, 10),
           0, 0, 0, 2, src_old, src_none, 0, src_yng, src_none, 0);
  set_case(8, "store then load split",
           encode_i(op_sw, 1, 2), encode_i(op_lw, 3, 4),
           0, 0, 0, 2, src_none, src_old, 0, src_none, src_yng, 0);
  set_case(9, "no overlap one group",
           encode_i(op_addi, 1, 14), encode_r(op_sub, 15, 16, 17),
           0, 0, 0, 1, src_old, src_yng, 0, src_none, src_none, 0);
  set_case(10, "load-use on older",
           encode_r(op_add, 21, 2, 18), encode_r(op_sub, 3, 4, 19),
           2, 21, 2, 1, src_old, src_yng, 0, src_none, src_none, 0);
  set_case(11, "load-use on younger",
           encode_i(op_addi, 6, 23), encode_i(op_sw, 24, 25),
           3, 25, 3, 1, src_old, src_yng, 0, src_none, src_none, 0);
  set_case(12, "load with no match",
           encode_r(op_add, 1, 2, 26), encode_r(op_sub, 3, 4, 27),
           2, 28, 0, 1, src_old, src_yng, 0, src_none, src_none, 0);
endtask

`endif

// File: test/tb_dual_issue.sv
`timescale 1ns/1ps

module tb_dual_issue;
  import issue_pkg::*;

  localparam int addr_width = 32;
  localparam int id_width   = 8;
  localparam int group_w    = 1 + 2 * (inst_width + addr_width + id_width);

  `include "tb_cases.svh"

  localparam int watchdog_cycles = 2 * n_cases * 8 + 20;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  logic                  in_ready;
  logic [inst_width-1:0] in_inst0;
  logic [addr_width-1:0] in_pc0;
  logic [id_width-1:0]   in_id0;
  logic [inst_width-1:0] in_inst1;
  logic [addr_width-1:0] in_pc1;
  logic [id_width-1:0]   in_id1;
  logic                  ex_load_valid;
  reg_idx_t              ex_load_rt;
  logic                  out_ready;
  logic                  out_valid;
  logic                  out_swapped;
  logic [inst_width-1:0] lane0_inst;
  logic [addr_width-1:0] lane0_pc;
  logic [id_width-1:0]   lane0_id;
  logic [inst_width-1:0] lane1_inst;
  logic [addr_width-1:0] lane1_pc;
  logic [id_width-1:0]   lane1_id;

  string                 name_tab     [n_cases];
  logic [inst_width-1:0] inst0_tab    [n_cases];
  logic [inst_width-1:0] inst1_tab    [n_cases];
  logic [addr_width-1:0] pc0_tab      [n_cases];
  logic [addr_width-1:0] pc1_tab      [n_cases];
  logic [id_width-1:0]   id0_tab      [n_cases];
  logic [id_width-1:0]   id1_tab      [n_cases];
  int                    load_cyc_tab [n_cases];
  reg_idx_t              load_rt_tab  [n_cases];
  int                    stall_tab    [n_cases];
  int                    ngroups_tab  [n_cases];
  int                    lane0_src    [n_cases][2];
  int                    lane1_src    [n_cases][2];
  int                    swap_tab     [n_cases][2];
  int                    accept_cyc   [n_cases];

  int                    exp_pass[$];   // expected groups in issue order.
  int                    exp_row[$];
  int                    exp_grp[$];
  int                    cyc;
  int                    checks;
  int                    errors;
  int                    row_err_base;
  logic                  random_bp;
  logic                  held_valid;
  logic [group_w-1:0]    held_group;

  dual_issue_hazard_unit #(.addr_width(addr_width), .id_width(id_width)) u_dual_issue_hazard_unit (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid),
    .in_inst0(in_inst0), .in_pc0(in_pc0), .in_id0(in_id0),
    .in_inst1(in_inst1), .in_pc1(in_pc1), .in_id1(in_id1),
    .ex_load_valid(ex_load_valid), .ex_load_rt(ex_load_rt), .out_ready(out_ready),
    .in_ready(in_ready), .out_valid(out_valid), .out_swapped(out_swapped),
    .lane0_inst(lane0_inst), .lane0_pc(lane0_pc), .lane0_id(lane0_id),
    .lane1_inst(lane1_inst), .lane1_pc(lane1_pc), .lane1_id(lane1_id)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // instruction encoding and table rows
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [inst_width-1:0] encode_r(input logic [5:0] op, input int rs,
                                                     input int rt, input int rd);
    return {op, 5'(rs), 5'(rt), 5'(rd), 11'd0};
  endfunction

  function automatic logic [inst_width-1:0] encode_i(input logic [5:0] op, input int rs,
                                                     input int rt);
    return {op, 5'(rs), 5'(rt), 16'h0004};
  endfunction

  task automatic set_case(input int idx, input string nm, input logic [inst_width-1:0] i0,
                          input logic [inst_width-1:0] i1, input int lcyc, input int lrt,
                          input int stall, input int ngrp, input int g0_l0, input int g0_l1,
                          input int g0_sw, input int g1_l0, input int g1_l1, input int g1_sw);
    name_tab[idx]     = nm;
    inst0_tab[idx]    = i0;
    inst1_tab[idx]    = i1;
    pc0_tab[idx]      = addr_width'(32'h1000 + idx * 8);
    pc1_tab[idx]      = addr_width'(32'h1004 + idx * 8);
    id0_tab[idx]      = id_width'(8'h20 + 2 * idx);
    id1_tab[idx]      = id_width'(8'h21 + 2 * idx);
    load_cyc_tab[idx] = lcyc;
    load_rt_tab[idx]  = 5'(lrt);
    stall_tab[idx]    = stall;
    ngroups_tab[idx]  = ngrp;
    lane0_src[idx][0] = g0_l0;
    lane1_src[idx][0] = g0_l1;
    swap_tab[idx][0]  = g0_sw;
    lane0_src[idx][1] = g1_l0;
    lane1_src[idx][1] = g1_l1;
    swap_tab[idx][1]  = g1_sw;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [group_w-1:0] group_bits();
    return {out_swapped, lane0_inst, lane0_pc, lane0_id, lane1_inst, lane1_pc, lane1_id};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_lane(input string lane, input int r, input int src,
                            input logic [inst_width-1:0] inst,
                            input logic [addr_width-1:0] pc, input logic [id_width-1:0] id);
    logic [inst_width-1:0] e_inst;
    logic [addr_width-1:0] e_pc;
    logic [id_width-1:0]   e_id;
    e_inst = '0;   // empty lane reads as zero.
    e_pc   = '0;
    e_id   = '0;
    if (src == src_old) begin
      e_inst = inst0_tab[r];
      e_pc   = pc0_tab[r];
      e_id   = id0_tab[r];
    end else if (src == src_yng) begin
      e_inst = inst1_tab[r];
      e_pc   = pc1_tab[r];
      e_id   = id1_tab[r];
    end
    check_value({lane, " inst"}, inst, e_inst);
    check_value({lane, " pc"}, 32'(pc), 32'(e_pc));
    check_value({lane, " id"}, 32'(id), 32'(e_id));
  endtask

  task automatic check_group();
    int r;
    int g;
    int p;
    if (exp_row.size() == 0) begin
      $display("an issue group arrived at %0t when none was left to expect", $time);
      errors++;
    end else begin
      p = exp_pass.pop_front();
      r = exp_row.pop_front();
      g = exp_grp.pop_front();
      if (g == 0) begin
        row_err_base = errors;
      end
      check_lane("lane0", r, lane0_src[r][g], lane0_inst, lane0_pc, lane0_id);
      check_lane("lane1", r, lane1_src[r][g], lane1_inst, lane1_pc, lane1_id);
      check_value("out_swapped", 32'(out_swapped), swap_tab[r][g]);
      if (p == 0) begin   // latency is exact while out_ready stays high.
        check_value("issue cycle", cyc, accept_cyc[r] + 2 + stall_tab[r] + g);
      end
      if (g == ngroups_tab[r] - 1) begin
        $display("pass %0d case %0d %s: %0d mismatches", p, r, name_tab[r],
                 errors - row_err_base);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // driver, monitor and watchdog
  ////////////////////////////////////////////////////////////////////////////

  task automatic offer_row(input int r);
    in_valid = 1'b1;
    in_inst0 = inst0_tab[r];
    in_pc0   = pc0_tab[r];
    in_id0   = id0_tab[r];
    in_inst1 = inst1_tab[r];
    in_pc1   = pc1_tab[r];
    in_id1   = id1_tab[r];
    #1;
    while (!in_ready) begin
      @(negedge clk);
      #1;
    end
    accept_cyc[r] = cyc;
    @(negedge clk);
    if (load_cyc_tab[r] > 0) begin   // load info only while the pair sits buffered.
      in_valid      = 1'b0;
      ex_load_valid = 1'b1;
      ex_load_rt    = load_rt_tab[r];
      repeat (load_cyc_tab[r]) @(negedge clk);
      ex_load_valid = 1'b0;
      ex_load_rt    = '0;
    end
  endtask

  always begin
    @(negedge clk);
    cyc++;
    out_ready = random_bp ? (($urandom % 3) != 0) : 1'b1;
    #1;
    if (held_valid) begin
      checks++;
      assert (out_valid && group_bits() === held_group) else begin
        $display("ERROR %0t: issue group changed while out_ready was low", $time);
        errors++;
      end
    end
    held_valid = out_valid && !out_ready;
    held_group = group_bits();
    if (out_valid && out_ready) begin
      check_group();
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: issue groups still missing after %0d cycles", watchdog_cycles);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    void'($urandom(4));
    rst_n         = 1'b0;
    in_valid      = 1'b0;
    in_inst0      = '0;
    in_pc0        = '0;
    in_id0        = '0;
    in_inst1      = '0;
    in_pc1        = '0;
    in_id1        = '0;
    ex_load_valid = 1'b0;
    ex_load_rt    = '0;
    out_ready     = 1'b1;
    cyc           = 0;
    checks        = 0;
    errors        = 0;
    row_err_base  = 0;
    random_bp     = 1'b0;
    held_valid    = 1'b0;
    held_group    = '0;
    load_case_table();
    for (int p = 0; p < 2; p++) begin
      for (int r = 0; r < n_cases; r++) begin
        for (int g = 0; g < ngroups_tab[r]; g++) begin
          exp_pass.push_back(p);
          exp_row.push_back(r);
          exp_grp.push_back(g);
        end
      end
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value("out_valid after reset", 32'(out_valid), 32'd0);
    check_value("in_ready after reset", 32'(in_ready), 32'd1);
    checks++;
    assert (group_bits() === '0) else begin
      $display("ERROR %0t: output registers not zero after reset", $time);
      errors++;
    end
    rst_n = 1'b1;
    // one pass with out_ready high, then one under random back-pressure.
    for (int p = 0; p < 2; p++) begin
      for (int r = 0; r < n_cases; r++) begin
        offer_row(r);
      end
      in_valid = 1'b0;
      while (exp_pass.size() != 0 && exp_pass[0] == p) begin
        @(negedge clk);
        #2;
      end
      random_bp = 1'b1;
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    $display("%0d cases run, %0d checks, %0d errors", 2 * n_cases, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
